// File: source/rv_pkg.sv
`default_nettype none

package rv_pkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_lui    = 7'b0110111,
        opc_system = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
        alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
    } alu_op_e;

    // writeback source
    typedef enum logic [1:0] {
        wb_alu = 2'd0,
        wb_mem = 2'd1
    } wb_sel_e;

    // per-format field views, msb first
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_e    opcode;
    } s_fmt_t;

    // branch offset is scattered, bit 0 implied zero
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        opcode_e    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        opcode_e     opcode;
    } u_fmt_t;

    // one instruction word, read through whichever view fits
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
    } instr_u;

    // apb register map
    localparam logic [3:0] ctrl_reg_offset    = 4'h0;
    localparam logic [3:0] status_reg_offset  = 4'h4;
    localparam logic [3:0] retired_reg_offset = 4'h8;

endpackage

`default_nettype wire

// File: source/rv_alu.sv
`default_nettype none

module rv_alu
    import rv_pkg::*;
(
    input  wire  [31:0] a,
    input  wire  [31:0] b,
    input  wire alu_op_e op,
    output logic [31:0] result,
    output logic        zero
);

    always_comb begin
        case (op)
            alu_add:    result = a + b;
            alu_sub:    result = a - b;
            // shift amount from low five bits only
            alu_sll:    result = a << b[4:0];
            alu_slt:    result = {31'd0, $signed(a) < $signed(b)};
            alu_sltu:   result = {31'd0, a < b};
            alu_xor:    result = a ^ b;
            alu_srl:    result = a >> b[4:0];
            alu_sra:    result = $unsigned($signed(a) >>> b[4:0]);
            alu_or:     result = a | b;
            alu_and:    result = a & b;
            // lui path, immediate straight through
            alu_pass_b: result = b;
            default:    result = '0;
        endcase
    end

    // branch compare uses sub, equal when zero
    assign zero = (result == 32'd0);

endmodule

`default_nettype wire

// File: source/rv_regfile.sv
`default_nettype none

module rv_regfile (
    input  wire         CLK,
    input  wire         RESET_N,
    input  wire  [4:0]  rs1_addr,
    input  wire  [4:0]  rs2_addr,
    input  wire  [4:0]  rd_addr,
    input  wire  [31:0] rd_data,
    input  wire         rd_we,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data
);

    logic        wr_live;
    logic [31:0] regs [32];

    // x0 never written, a live write targets x1..x31 only
    assign wr_live = rd_we && rd_addr != 5'd0;

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[rd_addr] <= rd_data;
        end
    end

    // write-through so writeback and decode can share a cycle
    assign rs1_data = (wr_live && rd_addr == rs1_addr) ? rd_data : regs[rs1_addr];
    assign rs2_data = (wr_live && rd_addr == rs2_addr) ? rd_data : regs[rs2_addr];

    // x0 reads zero even when a write to it is in flight
    a_x0_zero: assert property (@(posedge CLK) disable iff (!RESET_N)
        (rs1_addr == 5'd0 |-> rs1_data == '0) and (rs2_addr == 5'd0 |-> rs2_data == '0));

endmodule

`default_nettype wire

// File: source/rv_decode.sv
`default_nettype none

module rv_decode
    import rv_pkg::*;
(
    input  wire instr_u instr,
    output logic        reg_write,
    output logic        mem_read,
    output logic        mem_write,
    output logic        branch,
    output logic        alu_src_imm,
    output wb_sel_e     wb_sel,
    output logic        is_halt,
    output alu_op_e     alu_op,
    output logic [31:0] imm
);

    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;

    // funct3 to alu op, alt picks sub or sra
    function automatic alu_op_e arith_op(input logic [2:0] funct3, input logic alt);
        alu_op_e op;
        case (funct3)
            3'b000:  op = alt ? alu_sub : alu_add;
            3'b001:  op = alu_sll;
            3'b010:  op = alu_slt;
            3'b011:  op = alu_sltu;
            3'b100:  op = alu_xor;
            3'b101:  op = alt ? alu_sra : alu_srl;
            3'b110:  op = alu_or;
            default: op = alu_and;
        endcase
        return op;
    endfunction

    // sign-extended immediates, one per format view
    assign imm_i = {{20{instr.i.imm[11]}}, instr.i.imm};
    assign imm_s = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
    assign imm_b = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                    instr.b.imm10_5, instr.b.imm4_1, 1'b0};
    assign imm_u = {instr.u.imm, 12'd0};

    always_comb begin
        // defaults give a nop
        reg_write   = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        branch      = 1'b0;
        alu_src_imm = 1'b0;
        wb_sel      = wb_alu;
        is_halt     = 1'b0;
        alu_op      = alu_add;
        imm         = '0;
        case (instr.r.opcode)
            opc_op: begin
                reg_write = 1'b1;
                alu_op    = arith_op(instr.r.funct3, instr.r.funct7[5]);
            end
            opc_op_imm: begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
                imm         = imm_i;
                // no subi, bit 30 only selects srai
                alu_op = arith_op(instr.i.funct3,
                                  instr.r.funct7[5] && instr.i.funct3 == 3'b101);
            end
            opc_load: begin
                reg_write   = 1'b1;
                mem_read    = 1'b1;
                alu_src_imm = 1'b1;
                wb_sel      = wb_mem;
                imm         = imm_i;
            end
            opc_store: begin
                mem_write   = 1'b1;
                alu_src_imm = 1'b1;
                imm         = imm_s;
            end
            opc_branch: begin
                // compare by subtract, target from imm
                branch = 1'b1;
                alu_op = alu_sub;
                imm    = imm_b;
            end
            opc_lui: begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
                alu_op      = alu_pass_b;
                imm         = imm_u;
            end
            opc_system: begin
                // ecall only, other system encodings fall through as nop
                is_halt = (instr.i.funct3 == 3'b000) && (instr.i.imm == 12'd0);
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: source/rv_core.sv
`default_nettype none

module rv_core
    import rv_pkg::*;
#(
    parameter int ADDR_SIZE = 10
) (
    input  wire                  CLK,
    input  wire                  RESET_N,
    input  wire                  run,
    input  wire                  restart,
    input  wire  [31:0]          idata,
    output logic [ADDR_SIZE-1:0] iaddr,
    output logic [ADDR_SIZE-1:0] daddr,
    output logic [31:0]          ddata_w,
    input  wire  [31:0]          ddata_r,
    output logic                 mem_write,
    output logic                 mem_read,
    output logic                 done,
    output logic                 retire
);

    // byte address, word address plus two
    localparam int PC_W = ADDR_SIZE + 2;

    logic            advance;
    logic [PC_W-1:0] pc;

    // decode stage
    logic            valid_id;
    logic [PC_W-1:0] pc_id;
    instr_u          instr_id;
    logic            reg_write_id, mem_read_id, mem_write_id;
    logic            branch_id, alu_src_imm_id, halt_id;
    wb_sel_e         wb_sel_id;
    alu_op_e         alu_op_id;
    logic [31:0]     imm_id, rs1_data_id, rs2_data_id;

    // execute stage
    logic            valid_ex;
    logic [PC_W-1:0] pc_ex;
    logic [4:0]      rd_ex;
    logic            bne_ex, reg_write_ex, mem_read_ex, mem_write_ex;
    logic            branch_ex, alu_src_imm_ex, halt_ex;
    wb_sel_e         wb_sel_ex;
    alu_op_e         alu_op_ex;
    logic [31:0]     imm_ex, rs1_data_ex, rs2_data_ex;
    logic [31:0]     alu_b_ex, alu_result_ex, target_ex;
    logic            zero_ex;

    // memory stage
    logic            valid_ma;
    logic [4:0]      rd_ma;
    logic            bne_ma, reg_write_ma, mem_read_ma, mem_write_ma;
    logic            branch_ma, halt_ma, zero_ma, taken_ma;
    wb_sel_e         wb_sel_ma;
    logic [31:0]     alu_result_ma, rs2_data_ma;
    logic [PC_W-1:0] target_ma;

    // writeback stage
    logic            valid_wb;
    logic [4:0]      rd_wb;
    logic            reg_write_wb, halt_wb, rd_we;
    wb_sel_e         wb_sel_wb;
    logic [31:0]     alu_result_wb, load_data_wb, wb_data;

    // whole pipeline moves together or not at all
    assign advance = run & ~done;

    // fetch
    assign iaddr = pc[PC_W-1:2];

    rv_decode u_decode (
        .instr       (instr_id),
        .reg_write   (reg_write_id),
        .mem_read    (mem_read_id),
        .mem_write   (mem_write_id),
        .branch      (branch_id),
        .alu_src_imm (alu_src_imm_id),
        .wb_sel      (wb_sel_id),
        .is_halt     (halt_id),
        .alu_op      (alu_op_id),
        .imm         (imm_id)
    );

    // writes land only when the writeback slot really retires
    assign rd_we = valid_wb & reg_write_wb & advance;

    rv_regfile u_regfile (
        .CLK      (CLK),
        .RESET_N  (RESET_N),
        .rs1_addr (instr_id.r.rs1),
        .rs2_addr (instr_id.r.rs2),
        .rd_addr  (rd_wb),
        .rd_data  (wb_data),
        .rd_we    (rd_we),
        .rs1_data (rs1_data_id),
        .rs2_data (rs2_data_id)
    );

    // execute
    assign alu_b_ex = alu_src_imm_ex ? imm_ex : rs2_data_ex;

    rv_alu u_alu (
        .a      (rs1_data_ex),
        .b      (alu_b_ex),
        .op     (alu_op_ex),
        .result (alu_result_ex),
        .zero   (zero_ex)
    );

    // branch target, pc of the branch plus offset
    rv_alu u_target_alu (
        .a      ({{(32 - PC_W){1'b0}}, pc_ex}),
        .b      (imm_ex),
        .op     (alu_add),
        .result (target_ex),
        .zero   ()
    );

    // memory, branch resolved here
    assign taken_ma  = valid_ma & branch_ma & (bne_ma ? ~zero_ma : zero_ma);
    assign daddr     = alu_result_ma[PC_W-1:2];
    assign ddata_w   = rs2_data_ma;
    assign mem_write = valid_ma & mem_write_ma & advance;
    assign mem_read  = valid_ma & mem_read_ma & advance;

    // writeback
    assign wb_data = (wb_sel_wb == wb_mem) ? load_data_wb : alu_result_wb;
    assign retire  = valid_wb & advance;

    // pc, valid bits and halt state
    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            pc       <= '0;
            valid_id <= 1'b0;
            valid_ex <= 1'b0;
            valid_ma <= 1'b0;
            valid_wb <= 1'b0;
            done     <= 1'b0;
        end else if (restart) begin
            pc       <= '0;
            valid_id <= 1'b0;
            valid_ex <= 1'b0;
            valid_ma <= 1'b0;
            valid_wb <= 1'b0;
            done     <= 1'b0;
        end else if (advance) begin
            // three fetched slots behind a branch always run
            pc       <= taken_ma ? target_ma : pc + PC_W'(4);
            valid_id <= 1'b1;
            valid_ex <= valid_id;
            valid_ma <= valid_ex;
            valid_wb <= valid_ma;
            // ecall in writeback freezes everything from next cycle
            done     <= valid_wb & halt_wb;
        end
    end

    // stage payload, qualified by the valid bits above
    always_ff @(posedge CLK) begin
        if (advance) begin
            pc_id    <= pc;
            instr_id <= idata;

            pc_ex          <= pc_id;
            rd_ex          <= instr_id.r.rd;
            bne_ex         <= instr_id.b.funct3[0];
            reg_write_ex   <= reg_write_id;
            mem_read_ex    <= mem_read_id;
            mem_write_ex   <= mem_write_id;
            branch_ex      <= branch_id;
            alu_src_imm_ex <= alu_src_imm_id;
            halt_ex        <= halt_id;
            wb_sel_ex      <= wb_sel_id;
            alu_op_ex      <= alu_op_id;
            imm_ex         <= imm_id;
            rs1_data_ex    <= rs1_data_id;
            rs2_data_ex    <= rs2_data_id;

            rd_ma         <= rd_ex;
            bne_ma        <= bne_ex;
            reg_write_ma  <= reg_write_ex;
            mem_read_ma   <= mem_read_ex;
            mem_write_ma  <= mem_write_ex;
            branch_ma     <= branch_ex;
            halt_ma       <= halt_ex;
            zero_ma       <= zero_ex;
            wb_sel_ma     <= wb_sel_ex;
            alu_result_ma <= alu_result_ex;
            rs2_data_ma   <= rs2_data_ex;
            target_ma     <= target_ex[PC_W-1:0];

            rd_wb         <= rd_ma;
            reg_write_wb  <= reg_write_ma;
            halt_wb       <= halt_ma;
            wb_sel_wb     <= wb_sel_ma;
            alu_result_wb <= alu_result_ma;
            // load data sampled at the end of the memory stage
            load_data_wb  <= ddata_r;
        end
    end

    a_rd_wr_excl: assert property (@(posedge CLK) disable iff (!RESET_N)
        !(mem_read && mem_write));

    // halted core stays put until restart
    a_done_frozen: assert property (@(posedge CLK) disable iff (!RESET_N)
        done && !restart |=> $stable(pc) && $stable(valid_wb) && !retire);

endmodule

`default_nettype wire

// File: source/rv_ctrl_regs.sv
`default_nettype none

module rv_ctrl_regs
    import rv_pkg::*;
(
    input  wire         CLK,
    input  wire         RESET_N,
    input  wire         psel,
    input  wire         penable,
    input  wire         pwrite,
    input  wire  [3:0]  paddr,
    input  wire  [31:0] pwdata,
    output logic [31:0] prdata,
    input  wire         done,
    input  wire         retire,
    output logic        run,
    output logic        restart
);

    logic        ctrl_wr;
    logic [31:0] retired;

    // access phase of a write to ctrl, no wait states
    assign ctrl_wr = psel & penable & pwrite & (paddr == ctrl_reg_offset);

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            run     <= 1'b0;
            restart <= 1'b0;
            retired <= '0;
        end else begin
            if (ctrl_wr) begin
                run <= pwdata[0];
            end
            // bit 1 self-clears after one cycle
            restart <= ctrl_wr & pwdata[1];
            if (restart) begin
                retired <= '0;
            end else if (retire) begin
                retired <= retired + 32'd1;
            end
        end
    end

    // read mux, valid during the access cycle
    always_comb begin
        case (paddr)
            ctrl_reg_offset:    prdata = {31'd0, run};
            status_reg_offset:  prdata = {30'd0, run, done};
            retired_reg_offset: prdata = retired;
            default:            prdata = '0;
        endcase
    end

    a_apb_phase: assert property (@(posedge CLK) disable iff (!RESET_N)
        penable |-> psel && $past(psel));

endmodule

`default_nettype wire

// File: source/rv_soc.sv
`default_nettype none

module rv_soc #(
    parameter int ADDR_SIZE = 10
) (
    input  wire                  CLK,
    input  wire                  RESET_N,
    // instruction memory, combinational read
    output logic [ADDR_SIZE-1:0] iaddr,
    input  wire  [31:0]          idata,
    // data memory, word addressed
    output logic [ADDR_SIZE-1:0] daddr,
    output logic [31:0]          ddata_w,
    input  wire  [31:0]          ddata_r,
    output logic                 mem_write,
    output logic                 mem_read,
    // apb slave
    input  wire                  psel,
    input  wire                  penable,
    input  wire                  pwrite,
    input  wire  [3:0]           paddr,
    input  wire  [31:0]          pwdata,
    output logic [31:0]          prdata
);

    logic run;
    logic restart;
    logic done;
    logic retire;

    rv_core #(
        .ADDR_SIZE (ADDR_SIZE)
    ) u_core (
        .CLK       (CLK),
        .RESET_N   (RESET_N),
        .run       (run),
        .restart   (restart),
        .idata     (idata),
        .iaddr     (iaddr),
        .daddr     (daddr),
        .ddata_w   (ddata_w),
        .ddata_r   (ddata_r),
        .mem_write (mem_write),
        .mem_read  (mem_read),
        .done      (done),
        .retire    (retire)
    );

    // software side, run and restart control
    rv_ctrl_regs u_ctrl (
        .CLK     (CLK),
        .RESET_N (RESET_N),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .done    (done),
        .retire  (retire),
        .run     (run),
        .restart (restart)
    );

endmodule

`default_nettype wire

// File: tb/tb_rv_soc.sv
`default_nettype none

module tb_rv_soc
    import rv_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int ADDR_SIZE = 10;

    logic                 CLK;
    logic                 RESET_N;
    logic [ADDR_SIZE-1:0] iaddr;
    logic [ADDR_SIZE-1:0] daddr;
    logic [31:0]          idata;
    logic [31:0]          ddata_w;
    logic [31:0]          ddata_r;
    logic                 mem_write;
    logic                 mem_read;
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    logic [3:0]           paddr;
    logic [31:0]          pwdata;
    logic [31:0]          prdata;

    // raw data file, then the two memories
    logic [31:0] testdata [256];
    logic [31:0] imem [1024];
    logic [31:0] dmem [1024];

    int prog_words;
    int store_cnt;
    int exp_retired;
    int store_idx;
    int loads_seen;
    int errors;
    int tests_run;
    int tests_failed;
    int cycles = 0;
    int cycle_limit;
    int seed;
    logic watch_stores;
    logic paused;

    rv_soc #(
        .ADDR_SIZE (ADDR_SIZE)
    ) u_dut (
        .CLK       (CLK),
        .RESET_N   (RESET_N),
        .iaddr     (iaddr),
        .idata     (idata),
        .daddr     (daddr),
        .ddata_w   (ddata_w),
        .ddata_r   (ddata_r),
        .mem_write (mem_write),
        .mem_read  (mem_read),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata)
    );

    initial CLK = 1'b0;
    always #5 CLK = ~CLK;

    always @(posedge CLK) cycles <= cycles + 1;

    // both memories answer in the same cycle
    assign idata   = imem[iaddr];
    assign ddata_r = dmem[daddr];

    always @(posedge CLK) begin
        if (mem_write) begin
            dmem[daddr] <= ddata_w;
        end
    end

    // store list lives after the program words
    function automatic logic [31:0] exp_store_addr(input int k);
        return testdata[prog_words + 2 + 2 * k];
    endfunction

    function automatic logic [31:0] exp_store_data(input int k);
        return testdata[prog_words + 3 + 2 * k];
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("** Error: %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic flag_error(input string msg);
        errors++;
        $display("Error: %s", msg);
    endtask

    // setup cycle, then access cycle, no wait states
    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
        @(negedge CLK);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge CLK);
        penable = 1'b1;
        @(negedge CLK);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data);
        @(negedge CLK);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge CLK);
        penable = 1'b1;
        // prdata sampled at the end of the access cycle
        @(posedge CLK);
        data = prdata;
        @(negedge CLK);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // poll status until the core halts, bounded by the cycle limit
    task automatic wait_done();
        logic [31:0] status;
        status = '0;
        while (status[0] !== 1'b1) begin
            apb_read(status_reg_offset, status);
        end
    endtask

    task automatic check_run_end();
        logic [31:0] count;
        apb_read(retired_reg_offset, count);
        check("retired count", exp_retired, count);
        check("stores consumed", store_cnt, store_idx);
        // program contains a lw, so every run must read memory
        check("load issued", 32'd1, {31'd0, loads_seen != 0});
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("PASS: %s", name);
        end else begin
            tests_failed++;
            $display("FAIL: %s", name);
        end
    endtask

    // every store must match the next expected pair
    always @(posedge CLK) begin
        if (watch_stores && mem_read) begin
            loads_seen++;
            if (paused) begin
                flag_error("load issued while the core was paused");
            end
        end
        if (watch_stores && mem_write) begin
            if (paused) begin
                flag_error("store issued while the core was paused");
            end
            if (store_idx >= store_cnt) begin
                flag_error("store seen after the expected sequence ended");
            end else begin
                check("store address", exp_store_addr(store_idx), {22'd0, daddr});
                check("store data", exp_store_data(store_idx), ddata_w);
                store_idx++;
            end
        end
    end

    initial begin
        wait (cycle_limit > 0);
        while (cycles <= cycle_limit) @(posedge CLK);
        $display("Timeout: run did not finish within %0d cycles", cycle_limit);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        int          errs;
        int          gap;
        logic [31:0] val;
        RESET_N      = 1'b0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        watch_stores = 1'b0;
        paused       = 1'b0;
        store_idx    = 0;
        loads_seen   = 0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        cycle_limit  = 0;
        seed         = 32'h955e;
        for (int i = 0; i < 1024; i++) begin
            imem[i] = '0;
            dmem[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            testdata[i] = '0;
        end
        $readmemh("tb/program_testdata.txt", testdata);
        prog_words = testdata[0];
        for (int i = 0; i < prog_words; i++) begin
            imem[i] = testdata[i + 1];
        end
        store_cnt   = testdata[prog_words + 1];
        exp_retired = testdata[prog_words + 2 + 2 * store_cnt];
        // three runs of the program plus slack
        cycle_limit = 4 * prog_words * 3 + 500;

        repeat (2) @(negedge CLK);
        RESET_N = 1'b1;

        // idle core after reset
        errs = errors;
        apb_read(status_reg_offset, val);
        check("status after reset", 32'd0, val);
        apb_read(retired_reg_offset, val);
        check("retired after reset", 32'd0, val);
        repeat (20) begin
            @(posedge CLK);
            if (mem_write) begin
                flag_error("store issued while run was off");
            end
            if (mem_read) begin
                flag_error("load issued while run was off");
            end
        end
        end_test("reset state", errs);

        errs = errors;
        watch_stores = 1'b1;
        apb_write(ctrl_reg_offset, 32'd1);
        wait_done();
        end_test("program run", errs);

        errs = errors;
        apb_read(status_reg_offset, val);
        check("status at halt", 32'd3, val);
        check_run_end();
        end_test("completion", errs);

        // restart with run off, then toggle run at random gaps
        errs = errors;
        apb_write(ctrl_reg_offset, 32'd2);
        store_idx  = 0;
        loads_seen = 0;
        val = '0;
        while (val[0] !== 1'b1) begin
            paused = 1'b0;
            apb_write(ctrl_reg_offset, 32'd1);
            gap = ($random(seed) & 7) + 1;
            repeat (gap) @(posedge CLK);
            apb_write(ctrl_reg_offset, 32'd0);
            paused = 1'b1;
            gap = ($random(seed) & 7) + 1;
            repeat (gap) @(posedge CLK);
            apb_read(status_reg_offset, val);
        end
        paused = 1'b0;
        check_run_end();
        end_test("pause freeze", errs);

        errs = errors;
        apb_write(ctrl_reg_offset, 32'd2);
        apb_read(status_reg_offset, val);
        check("status after restart", 32'd0, val);
        apb_read(retired_reg_offset, val);
        check("retired after restart", 32'd0, val);
        store_idx  = 0;
        loads_seen = 0;
        apb_write(ctrl_reg_offset, 32'd1);
        wait_done();
        check_run_end();
        end_test("restart", errs);

        watch_stores = 1'b0;
        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/program_testdata.txt
// program word count, program words, store count,
// store pairs as word address then data, expected retired count (all hex)
37
00500093 FFD00113 123451B7 10000213 00000013
00000013 002082B3 40208333 0020C3B3 00522023
00622223 00722423 00112433 001134B3 00109533
00822623 00922823 00A22A23 40115593 0041D613
0F00E693 00B22C23 00C22E23 02D22023 0FF17713
00422783 0030E833 02E22223 02F22423 03022623
00608863 00000013 00000013 00000013 00209C63
01100893 00000013 00000013 02122823 02122823
03122A23 00108E63 02200913 00000013 00000013
02122823 02122823 02122823 03222C23 00109463
03300993 00000013 00000013 03322E23 00000073
// stores
0F
40 00000002
41 00000008
42 FFFFFFF8
43 00000001
44 00000000
45 000000A0
46 FFFFFFFE
47 01234500
48 000000F5
49 000000FD
4A 00000008
4B 12345005
4D 00000011
4E 00000022
4F 00000033
// retired
32

// File: filelist.f
source/rv_pkg.sv
source/rv_alu.sv
source/rv_regfile.sv
source/rv_decode.sv
source/rv_core.sv
source/rv_ctrl_regs.sv
source/rv_soc.sv
tb/tb_rv_soc.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check sim.log for the pass message"
	@echo "  clean  remove build output and logs"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert -f filelist.f --top-module tb_rv_soc -Mdir obj_dir
	./obj_dir/Vtb_rv_soc | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
